// File: ecc_dsa_config.svh
// Width and curve-constant macros for the ECDSA control engine, included by the package and RTL
`ifndef ECC_DSA_CONFIG_SVH
`define ECC_DSA_CONFIG_SVH

`define ECC_DATA_W 32
`define ECC_ADDR_W 8
`define ECC_OPR_W  6
`define ECC_ID_W   6
`define ECC_OP_W   4
`define ECC_UOP_W  (`ECC_OP_W + `ECC_ID_W + `ECC_OPR_W)

// Curve constants, Montgomery domain where it applies
`define ECC_CONST_ZERO 32'h0000_0000
`define ECC_CONST_ONE  32'h0000_0001
`define ECC_CONST_A    32'hFFFF_FFFC
`define ECC_CONST_3B   32'h5AC6_35D8
`define ECC_CONST_R2P  32'h0000_0003
`define ECC_CONST_GX   32'h6B17_D1F2
`define ECC_CONST_GY   32'h4FE3_42E2
`define ECC_CONST_R2Q  32'h66E1_2D94
`define ECC_CONST_ONEQ 32'h4319_055A

`endif

// File: ecc_dsa_pkg.sv
// Shared opcodes, register IDs, operand addresses and program bounds; import where used
`include "ecc_dsa_config.svh"

package ecc_dsa_pkg;

  // Micro-op opcodes
  localparam logic [`ECC_OP_W-1:0] DSA_UOP_NOP        = 4'h0,
                                   DSA_UOP_WR_CORE    = 4'h1,
                                   DSA_UOP_RD_CORE    = 4'h2,
                                   DSA_UOP_WR_SCALAR  = 4'h3,
                                   DSA_UOP_SCALAR_SCA = 4'h4,
                                   DSA_UOP_HMAC_DRBG  = 4'h5,
                                   DSA_UOP_KEYGEN     = 4'h6,
                                   DSA_UOP_SIGN       = 4'h7,
                                   DSA_UOP_VERIFY0    = 4'h8,
                                   DSA_UOP_VERIFY1    = 4'h9,
                                   DSA_UOP_VERIFY2    = 4'hA;

  // Register IDs; constants sit below CONST_LIMIT_ID
  localparam logic [`ECC_ID_W-1:0] NOP_ID         = 6'd0,
                                   CONST_ZERO_ID  = 6'd1,
                                   CONST_ONE_ID   = 6'd2,
                                   CONST_A_ID     = 6'd3,
                                   CONST_3B_ID    = 6'd4,
                                   CONST_R2P_ID   = 6'd5,
                                   CONST_GX_ID    = 6'd6,
                                   CONST_GY_ID    = 6'd7,
                                   CONST_R2Q_ID   = 6'd8,
                                   CONST_ONEQ_ID  = 6'd9,
                                   CONST_LIMIT_ID = 6'd10,
                                   PRIVKEY_ID     = 6'd16,
                                   MSG_ID         = 6'd17,
                                   R_ID           = 6'd18,
                                   S_ID           = 6'd19,
                                   PUBKEYX_ID     = 6'd20,
                                   PUBKEYY_ID     = 6'd21,
                                   LAMBDA_ID      = 6'd22,
                                   MASKING_ID     = 6'd23,
                                   SCALAR_G_ID    = 6'd24,
                                   SCALAR_ID      = 6'd25,
                                   SCALAR_PK_ID   = 6'd26,
                                   VERIFY_R_ID    = 6'd27;

  // Operand memory slots
  localparam logic [`ECC_OPR_W-1:0] UOP_OPR_DONTCARE   = 6'd0,
                                    UOP_OPR_CONST_ZERO = 6'd1,
                                    UOP_OPR_CONST_ONE  = 6'd2,
                                    UOP_OPR_CONST_A    = 6'd3,
                                    UOP_OPR_CONST_3B   = 6'd4,
                                    UOP_OPR_CONST_R2P  = 6'd5,
                                    UOP_OPR_CONST_GX   = 6'd6,
                                    UOP_OPR_CONST_GY   = 6'd7,
                                    UOP_OPR_CONST_R2Q  = 6'd8,
                                    UOP_OPR_CONST_ONEQ = 6'd9,
                                    UOP_OPR_SCALAR_G   = 6'd16,
                                    UOP_OPR_SCALAR_PK  = 6'd17,
                                    UOP_OPR_LAMBDA     = 6'd18,
                                    UOP_OPR_MASKING    = 6'd19,
                                    UOP_OPR_HASH_MSG   = 6'd20,
                                    UOP_OPR_PRIVKEY    = 6'd21,
                                    UOP_OPR_SIGN_R     = 6'd22,
                                    UOP_OPR_SIGN_S     = 6'd23,
                                    UOP_OPR_QX_AFFN    = 6'd24,
                                    UOP_OPR_QY_AFFN    = 6'd25;

  // Program bounds in the micro-op ROM
  localparam logic [`ECC_ADDR_W-1:0] DSA_INIT_S = 8'd0,
                                     DSA_INIT_E = 8'd10,
                                     DSA_KG_S   = 8'd16,
                                     DSA_KG_E   = 8'd26,
                                     DSA_SGN_S  = 8'd32,
                                     DSA_SGN_E  = 8'd44,
                                     DSA_VER_S  = 8'd48,
                                     DSA_VER_E  = 8'd65;

  localparam logic [1:0] DSA_MODE_INIT   = 2'd0,
                         DSA_MODE_KEYGEN = 2'd1,
                         DSA_MODE_SIGN   = 2'd2,
                         DSA_MODE_VERIFY = 2'd3;

endpackage

// File: ecc_dsa_uop_if.sv
// Micro-op channel from the controller to the executor, with the completion pulse back
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

interface ecc_dsa_uop_if;
  logic                  uop_valid;
  logic [`ECC_OP_W-1:0]  uop_op;
  logic [`ECC_ID_W-1:0]  uop_id;
  logic [`ECC_OPR_W-1:0] uop_opr;
  logic                  uop_done;

  modport ctrl (output uop_valid, output uop_op, output uop_id, output uop_opr,
                input uop_done);

  modport exec (input uop_valid, input uop_op, input uop_id, input uop_opr,
                output uop_done);
endinterface

// File: ecc_dsa_sequencer.sv
// Registered micro-op ROM with the init, keygen, sign and verify programs
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module ecc_dsa_sequencer
  import ecc_dsa_pkg::*;
#(
  parameter int ADDR_WIDTH = `ECC_ADDR_W,
  parameter int DATA_WIDTH = `ECC_UOP_W
) (
  input  logic                  clka,
  input  logic                  reset_n,
  input  logic                  ena,
  input  logic [ADDR_WIDTH-1:0] addra,
  output logic [DATA_WIDTH-1:0] douta
);

  always_ff @(posedge clka or negedge reset_n) begin
    if (!reset_n) begin
      douta <= '0;
    end else if (ena) begin
      case (addra)
        // Init: load the curve constants
        DSA_INIT_S        : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
        DSA_INIT_S + 8'd1 : douta <= {DSA_UOP_WR_CORE, CONST_ZERO_ID, UOP_OPR_CONST_ZERO};
        DSA_INIT_S + 8'd2 : douta <= {DSA_UOP_WR_CORE, CONST_ONE_ID, UOP_OPR_CONST_ONE};
        DSA_INIT_S + 8'd3 : douta <= {DSA_UOP_WR_CORE, CONST_A_ID, UOP_OPR_CONST_A};
        DSA_INIT_S + 8'd4 : douta <= {DSA_UOP_WR_CORE, CONST_3B_ID, UOP_OPR_CONST_3B};
        DSA_INIT_S + 8'd5 : douta <= {DSA_UOP_WR_CORE, CONST_R2P_ID, UOP_OPR_CONST_R2P};
        DSA_INIT_S + 8'd6 : douta <= {DSA_UOP_WR_CORE, CONST_GX_ID, UOP_OPR_CONST_GX};
        DSA_INIT_S + 8'd7 : douta <= {DSA_UOP_WR_CORE, CONST_GY_ID, UOP_OPR_CONST_GY};
        DSA_INIT_S + 8'd8 : douta <= {DSA_UOP_WR_CORE, CONST_R2Q_ID, UOP_OPR_CONST_R2Q};
        DSA_INIT_S + 8'd9 : douta <= {DSA_UOP_WR_CORE, CONST_ONEQ_ID, UOP_OPR_CONST_ONEQ};
        DSA_INIT_S + 8'd10: douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};

        // Keygen
        DSA_KG_S          : douta <= {DSA_UOP_HMAC_DRBG, NOP_ID, UOP_OPR_DONTCARE};
        DSA_KG_S + 8'd1   : douta <= {DSA_UOP_WR_CORE, SCALAR_G_ID, UOP_OPR_SCALAR_G};
        DSA_KG_S + 8'd2   : douta <= {DSA_UOP_RD_CORE, PRIVKEY_ID, UOP_OPR_SCALAR_G};
        DSA_KG_S + 8'd3   : douta <= {DSA_UOP_SCALAR_SCA, SCALAR_G_ID, UOP_OPR_DONTCARE};
        DSA_KG_S + 8'd4   : douta <= {DSA_UOP_WR_SCALAR, SCALAR_ID, UOP_OPR_DONTCARE};
        DSA_KG_S + 8'd5   : douta <= {DSA_UOP_WR_CORE, LAMBDA_ID, UOP_OPR_LAMBDA};
        DSA_KG_S + 8'd6   : douta <= {DSA_UOP_KEYGEN, NOP_ID, UOP_OPR_DONTCARE};
        DSA_KG_S + 8'd7   : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
        DSA_KG_S + 8'd8   : douta <= {DSA_UOP_RD_CORE, PUBKEYX_ID, UOP_OPR_QX_AFFN};
        DSA_KG_S + 8'd9   : douta <= {DSA_UOP_RD_CORE, PUBKEYY_ID, UOP_OPR_QY_AFFN};
        DSA_KG_S + 8'd10  : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};

        // Sign
        DSA_SGN_S         : douta <= {DSA_UOP_WR_CORE, MSG_ID, UOP_OPR_HASH_MSG};
        DSA_SGN_S + 8'd1  : douta <= {DSA_UOP_WR_CORE, PRIVKEY_ID, UOP_OPR_PRIVKEY};
        DSA_SGN_S + 8'd2  : douta <= {DSA_UOP_HMAC_DRBG, NOP_ID, UOP_OPR_DONTCARE};
        DSA_SGN_S + 8'd3  : douta <= {DSA_UOP_WR_CORE, SCALAR_G_ID, UOP_OPR_SCALAR_G};
        DSA_SGN_S + 8'd4  : douta <= {DSA_UOP_SCALAR_SCA, SCALAR_G_ID, UOP_OPR_DONTCARE};
        DSA_SGN_S + 8'd5  : douta <= {DSA_UOP_WR_SCALAR, SCALAR_ID, UOP_OPR_DONTCARE};
        DSA_SGN_S + 8'd6  : douta <= {DSA_UOP_WR_CORE, LAMBDA_ID, UOP_OPR_LAMBDA};
        DSA_SGN_S + 8'd7  : douta <= {DSA_UOP_WR_CORE, MASKING_ID, UOP_OPR_MASKING};
        DSA_SGN_S + 8'd8  : douta <= {DSA_UOP_SIGN, NOP_ID, UOP_OPR_DONTCARE};
        DSA_SGN_S + 8'd9  : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
        DSA_SGN_S + 8'd10 : douta <= {DSA_UOP_RD_CORE, R_ID, UOP_OPR_SIGN_R};
        DSA_SGN_S + 8'd11 : douta <= {DSA_UOP_RD_CORE, S_ID, UOP_OPR_SIGN_S};
        DSA_SGN_S + 8'd12 : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};

        // Verify, in three core passes
        DSA_VER_S         : douta <= {DSA_UOP_WR_CORE, MSG_ID, UOP_OPR_HASH_MSG};
        DSA_VER_S + 8'd1  : douta <= {DSA_UOP_WR_CORE, R_ID, UOP_OPR_SIGN_R};
        DSA_VER_S + 8'd2  : douta <= {DSA_UOP_WR_CORE, S_ID, UOP_OPR_SIGN_S};
        DSA_VER_S + 8'd3  : douta <= {DSA_UOP_WR_CORE, CONST_ONE_ID, UOP_OPR_LAMBDA};
        DSA_VER_S + 8'd4  : douta <= {DSA_UOP_VERIFY0, NOP_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd5  : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd6  : douta <= {DSA_UOP_RD_CORE, SCALAR_G_ID, UOP_OPR_SCALAR_G};
        DSA_VER_S + 8'd7  : douta <= {DSA_UOP_RD_CORE, SCALAR_PK_ID, UOP_OPR_SCALAR_PK};
        DSA_VER_S + 8'd8  : douta <= {DSA_UOP_WR_SCALAR, SCALAR_G_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd9  : douta <= {DSA_UOP_VERIFY1, NOP_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd10 : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd11 : douta <= {DSA_UOP_WR_CORE, PUBKEYX_ID, UOP_OPR_QX_AFFN};
        DSA_VER_S + 8'd12 : douta <= {DSA_UOP_WR_CORE, PUBKEYY_ID, UOP_OPR_QY_AFFN};
        DSA_VER_S + 8'd13 : douta <= {DSA_UOP_WR_SCALAR, SCALAR_PK_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd14 : douta <= {DSA_UOP_VERIFY2, NOP_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd15 : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
        DSA_VER_S + 8'd16 : douta <= {DSA_UOP_RD_CORE, VERIFY_R_ID, UOP_OPR_QX_AFFN};
        DSA_VER_S + 8'd17 : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};

        default           : douta <= {DSA_UOP_NOP, NOP_ID, UOP_OPR_DONTCARE};
      endcase
    end
  end

endmodule

// File: ecc_dsa_ctrl.sv
// Program controller; accepts a command, walks the ROM and issues one micro-op at a time
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module ecc_dsa_ctrl
  import ecc_dsa_pkg::*;
(
  input  logic                  clka,
  input  logic                  reset_n,
  input  logic                  cmd_start,
  input  logic [1:0]            cmd_mode,
  output logic                  busy,
  output logic                  cmd_done,
  output logic                  ena,
  output logic [`ECC_ADDR_W-1:0] addra,
  input  logic [`ECC_UOP_W-1:0]  douta,
  ecc_dsa_uop_if.ctrl           uop
);

  localparam logic [2:0] ST_IDLE      = 3'd0,
                         ST_FETCH     = 3'd1,
                         ST_WAIT_ROM  = 3'd2,
                         ST_ISSUE     = 3'd3,
                         ST_WAIT_DONE = 3'd4;

  logic [2:0]             state;
  logic [`ECC_ADDR_W-1:0] pc;
  logic [`ECC_ADDR_W-1:0] end_addr;
  logic [`ECC_ADDR_W-1:0] start_sel;
  logic [`ECC_ADDR_W-1:0] end_sel;

  // Program bounds per mode
  always_comb begin
    case (cmd_mode)
      DSA_MODE_INIT: begin
        start_sel = DSA_INIT_S;
        end_sel   = DSA_INIT_E;
      end
      DSA_MODE_KEYGEN: begin
        start_sel = DSA_KG_S;
        end_sel   = DSA_KG_E;
      end
      DSA_MODE_SIGN: begin
        start_sel = DSA_SGN_S;
        end_sel   = DSA_SGN_E;
      end
      default: begin
        start_sel = DSA_VER_S;
        end_sel   = DSA_VER_E;
      end
    endcase
  end

  // --------------------
  // Sequencing FSM
  // --------------------
  always_ff @(posedge clka or negedge reset_n) begin
    if (!reset_n) begin
      state    <= ST_IDLE;
      pc       <= '0;
      end_addr <= '0;
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_start) begin
            pc       <= start_sel;
            end_addr <= end_sel;
            state    <= ST_FETCH;
          end
        end
        ST_FETCH:    state <= ST_WAIT_ROM;
        ST_WAIT_ROM: state <= ST_ISSUE;
        ST_ISSUE:    state <= ST_WAIT_DONE;
        ST_WAIT_DONE: begin
          if (uop.uop_done) begin
            if (pc == end_addr) begin
              state    <= ST_IDLE;
              cmd_done <= 1'b1;
            end else begin
              pc    <= pc + 1'b1;
              state <= ST_FETCH;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign busy  = (state != ST_IDLE);
  assign ena   = (state == ST_FETCH);
  assign addra = pc;

  // ROM word holds until the next fetch
  assign uop.uop_valid = (state == ST_ISSUE);
  assign uop.uop_op    = douta[`ECC_UOP_W-1 -: `ECC_OP_W];
  assign uop.uop_id    = douta[`ECC_ID_W+`ECC_OPR_W-1 -: `ECC_ID_W];
  assign uop.uop_opr   = douta[`ECC_OPR_W-1:0];

endmodule

// File: ecc_dsa_uop_exec.sv
// Micro-op executor; moves words in and out of operand memory and drives the core commands
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module ecc_dsa_uop_exec
  import ecc_dsa_pkg::*;
(
  input  logic                   clka,
  input  logic                   reset_n,
  ecc_dsa_uop_if.exec            uop,
  output logic [`ECC_ID_W-1:0]   key_rd_id,
  input  logic [`ECC_DATA_W-1:0] key_rd_data,
  output logic                   res_we,
  output logic [`ECC_ID_W-1:0]   res_id,
  output logic [`ECC_DATA_W-1:0] res_data,
  output logic                   pm_start,
  output logic [`ECC_OP_W-1:0]   pm_op,
  output logic [`ECC_ID_W-1:0]   pm_id,
  input  logic                   pm_done,
  input  logic [`ECC_OPR_W-1:0]  core_addr,
  input  logic                   core_we,
  input  logic [`ECC_DATA_W-1:0] core_wdata,
  output logic [`ECC_DATA_W-1:0] core_rdata
);

  logic [`ECC_DATA_W-1:0] opr_mem [2**`ECC_OPR_W];
  logic                   move_in;
  logic                   move_out;
  logic                   is_local;
  logic                   pm_wait;
  logic                   done_q;

  // Opcode decode
  assign move_in  = uop.uop_valid && (uop.uop_op == DSA_UOP_WR_CORE);
  assign move_out = uop.uop_valid && (uop.uop_op == DSA_UOP_RD_CORE);
  assign is_local = (uop.uop_op == DSA_UOP_NOP) || (uop.uop_op == DSA_UOP_WR_CORE) ||
                    (uop.uop_op == DSA_UOP_RD_CORE);

  assign key_rd_id  = uop.uop_id;
  assign res_we     = move_out;
  assign res_id     = uop.uop_id;
  assign res_data   = opr_mem[uop.uop_opr];
  assign core_rdata = opr_mem[core_addr];

  // Operand memory; a core write to the same slot lands last
  always_ff @(posedge clka) begin
    if (move_in) begin
      opr_mem[uop.uop_opr] <= key_rd_data;
    end
    if (core_we) begin
      opr_mem[core_addr] <= core_wdata;
    end
  end

  // --------------------
  // Completion and core handshake
  // --------------------
  always_ff @(posedge clka or negedge reset_n) begin
    if (!reset_n) begin
      done_q   <= 1'b0;
      pm_start <= 1'b0;
      pm_wait  <= 1'b0;
    end else begin
      done_q   <= 1'b0;
      pm_start <= 1'b0;
      if (uop.uop_valid) begin
        if (is_local) begin
          done_q <= 1'b1;
        end else begin
          pm_start <= 1'b1;
          pm_wait  <= 1'b1;
        end
      end else if (pm_wait && pm_done) begin
        pm_wait <= 1'b0;
        done_q  <= 1'b1;
      end
    end
  end

  // Command word held for the core
  always_ff @(posedge clka) begin
    if (uop.uop_valid && !is_local) begin
      pm_op <= uop.uop_op;
      pm_id <= uop.uop_id;
    end
  end

  assign uop.uop_done = done_q;

endmodule

// File: ecc_dsa_key_bank.sv
// Input key bank; host-written key words plus the read-only curve constant table
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module ecc_dsa_key_bank
  import ecc_dsa_pkg::*;
(
  input  logic                   clka,
  input  logic                   reset_n,
  input  logic                   key_we,
  input  logic [`ECC_ID_W-1:0]   key_id,
  input  logic [`ECC_DATA_W-1:0] key_wdata,
  input  logic [`ECC_ID_W-1:0]   key_rd_id,
  output logic [`ECC_DATA_W-1:0] key_rd_data
);

  localparam int HOST_N = MASKING_ID - PRIVKEY_ID + 1;

  logic [`ECC_DATA_W-1:0] host_regs [HOST_N];
  logic [2:0]             wr_off;
  logic [2:0]             rd_off;
  logic                   wr_host;
  logic                   rd_host;

  // Host IDs are contiguous from PRIVKEY_ID
  assign wr_off  = 3'(key_id - PRIVKEY_ID);
  assign rd_off  = 3'(key_rd_id - PRIVKEY_ID);
  assign wr_host = key_we && (key_id >= PRIVKEY_ID) && (key_id <= MASKING_ID);
  assign rd_host = (key_rd_id >= PRIVKEY_ID) && (key_rd_id <= MASKING_ID);

  always_ff @(posedge clka or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < HOST_N; i++) begin
        host_regs[i] <= '0;
      end
    end else if (wr_host) begin
      host_regs[wr_off] <= key_wdata;
    end
  end

  always_comb begin
    key_rd_data = '0;
    if (key_rd_id < CONST_LIMIT_ID) begin
      case (key_rd_id)
        CONST_ZERO_ID: key_rd_data = `ECC_CONST_ZERO;
        CONST_ONE_ID:  key_rd_data = `ECC_CONST_ONE;
        CONST_A_ID:    key_rd_data = `ECC_CONST_A;
        CONST_3B_ID:   key_rd_data = `ECC_CONST_3B;
        CONST_R2P_ID:  key_rd_data = `ECC_CONST_R2P;
        CONST_GX_ID:   key_rd_data = `ECC_CONST_GX;
        CONST_GY_ID:   key_rd_data = `ECC_CONST_GY;
        CONST_R2Q_ID:  key_rd_data = `ECC_CONST_R2Q;
        CONST_ONEQ_ID: key_rd_data = `ECC_CONST_ONEQ;
        default:       key_rd_data = '0;
      endcase
    end else if (rd_host) begin
      key_rd_data = host_regs[rd_off];
    end
  end

endmodule

// File: ecc_dsa_result_bank.sv
// Result bank; public key, signature and verify words with the host read port and verify flag
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module ecc_dsa_result_bank
  import ecc_dsa_pkg::*;
(
  input  logic                   clka,
  input  logic                   reset_n,
  input  logic                   res_we,
  input  logic [`ECC_ID_W-1:0]   res_id,
  input  logic [`ECC_DATA_W-1:0] res_data,
  input  logic [`ECC_ID_W-1:0]   res_rd_id,
  output logic [`ECC_DATA_W-1:0] res_rd_data,
  output logic                   verify_ok
);

  logic [`ECC_DATA_W-1:0] pubkeyx_q;
  logic [`ECC_DATA_W-1:0] pubkeyy_q;
  logic [`ECC_DATA_W-1:0] r_q;
  logic [`ECC_DATA_W-1:0] s_q;
  logic [`ECC_DATA_W-1:0] verify_r_q;

  always_ff @(posedge clka or negedge reset_n) begin
    if (!reset_n) begin
      pubkeyx_q  <= '0;
      pubkeyy_q  <= '0;
      r_q        <= '0;
      s_q        <= '0;
      verify_r_q <= '0;
      verify_ok  <= 1'b0;
    end else if (res_we) begin
      case (res_id)
        PUBKEYX_ID: pubkeyx_q <= res_data;
        PUBKEYY_ID: pubkeyy_q <= res_data;
        R_ID:       r_q       <= res_data;
        S_ID:       s_q       <= res_data;
        VERIFY_R_ID: begin
          verify_r_q <= res_data;
          // Recomputed x against the r held from sign
          verify_ok  <= (res_data == r_q);
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (res_rd_id)
      PUBKEYX_ID:  res_rd_data = pubkeyx_q;
      PUBKEYY_ID:  res_rd_data = pubkeyy_q;
      R_ID:        res_rd_data = r_q;
      S_ID:        res_rd_data = s_q;
      VERIFY_R_ID: res_rd_data = verify_r_q;
      default:     res_rd_data = '0;
    endcase
  end

endmodule

// File: ecc_dsa_top.sv
// Top level of the ECDSA control engine; wires controller, ROM, executor and both banks
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module ecc_dsa_top (
  input  logic                   clka,
  input  logic                   reset_n,
  input  logic                   key_we,
  input  logic [`ECC_ID_W-1:0]   key_id,
  input  logic [`ECC_DATA_W-1:0] key_wdata,
  input  logic                   cmd_start,
  input  logic [1:0]             cmd_mode,
  output logic                   busy,
  output logic                   cmd_done,
  input  logic [`ECC_ID_W-1:0]   res_rd_id,
  output logic [`ECC_DATA_W-1:0] res_rd_data,
  output logic                   verify_ok,
  output logic                   pm_start,
  output logic [`ECC_OP_W-1:0]   pm_op,
  output logic [`ECC_ID_W-1:0]   pm_id,
  input  logic                   pm_done,
  input  logic [`ECC_OPR_W-1:0]  core_addr,
  input  logic                   core_we,
  input  logic [`ECC_DATA_W-1:0] core_wdata,
  output logic [`ECC_DATA_W-1:0] core_rdata
);

  logic                   ena;
  logic [`ECC_ADDR_W-1:0] addra;
  logic [`ECC_UOP_W-1:0]  douta;
  logic [`ECC_ID_W-1:0]   key_rd_id;
  logic [`ECC_DATA_W-1:0] key_rd_data;
  logic                   res_we;
  logic [`ECC_ID_W-1:0]   res_id;
  logic [`ECC_DATA_W-1:0] res_data;

  ecc_dsa_uop_if uop_bus ();

  ecc_dsa_ctrl u_ctrl (
    .clka      (clka),
    .reset_n   (reset_n),
    .cmd_start (cmd_start),
    .cmd_mode  (cmd_mode),
    .busy      (busy),
    .cmd_done  (cmd_done),
    .ena       (ena),
    .addra     (addra),
    .douta     (douta),
    .uop       (uop_bus.ctrl)
  );

  ecc_dsa_sequencer u_sequencer (
    .clka    (clka),
    .reset_n (reset_n),
    .ena     (ena),
    .addra   (addra),
    .douta   (douta)
  );

  ecc_dsa_uop_exec u_exec (
    .clka        (clka),
    .reset_n     (reset_n),
    .uop         (uop_bus.exec),
    .key_rd_id   (key_rd_id),
    .key_rd_data (key_rd_data),
    .res_we      (res_we),
    .res_id      (res_id),
    .res_data    (res_data),
    .pm_start    (pm_start),
    .pm_op       (pm_op),
    .pm_id       (pm_id),
    .pm_done     (pm_done),
    .core_addr   (core_addr),
    .core_we     (core_we),
    .core_wdata  (core_wdata),
    .core_rdata  (core_rdata)
  );

  ecc_dsa_key_bank u_key_bank (
    .clka        (clka),
    .reset_n     (reset_n),
    .key_we      (key_we),
    .key_id      (key_id),
    .key_wdata   (key_wdata),
    .key_rd_id   (key_rd_id),
    .key_rd_data (key_rd_data)
  );

  ecc_dsa_result_bank u_result_bank (
    .clka        (clka),
    .reset_n     (reset_n),
    .res_we      (res_we),
    .res_id      (res_id),
    .res_data    (res_data),
    .res_rd_id   (res_rd_id),
    .res_rd_data (res_rd_data),
    .verify_ok   (verify_ok)
  );

endmodule

// File: tb_ecc_dsa_top.sv
// Self-checking testbench for the ECDSA control engine; replays the pattern file against a core model
`timescale 1ns/1ns
`include "ecc_dsa_config.svh"

module tb_ecc_dsa_top
  import ecc_dsa_pkg::*;
();

  localparam int CLK_NS      = 8;
  // Micro-ops over all five runs, and the worst cycles one of them can take
  localparam int UOP_TOTAL   = 71;
  localparam int UOP_WORST   = 20;
  localparam int WATCHDOG_NS = (UOP_TOTAL * UOP_WORST + 400) * CLK_NS;

  logic                   clka = 1'b0;
  logic                   reset_n;
  logic                   key_we;
  logic [`ECC_ID_W-1:0]   key_id;
  logic [`ECC_DATA_W-1:0] key_wdata;
  logic                   cmd_start;
  logic [1:0]             cmd_mode;
  logic                   busy;
  logic                   cmd_done;
  logic [`ECC_ID_W-1:0]   res_rd_id;
  logic [`ECC_DATA_W-1:0] res_rd_data;
  logic                   verify_ok;
  logic                   pm_start;
  logic [`ECC_OP_W-1:0]   pm_op;
  logic [`ECC_ID_W-1:0]   pm_id;
  logic                   pm_done;
  logic [`ECC_OPR_W-1:0]  core_addr;
  logic                   core_we;
  logic [`ECC_DATA_W-1:0] core_wdata;
  logic [`ECC_DATA_W-1:0] core_rdata;

  logic [31:0] pat [0:19];
  logic [3:0]  op_log [$];
  logic [5:0]  id_log [$];
  logic [31:0] verify_qx;
  logic        sign_seen;
  integer      seed;
  int          err_count = 0;
  int          check_count = 0;
  int          done_count;

  ecc_dsa_top UUT (
    .clka        (clka),
    .reset_n     (reset_n),
    .key_we      (key_we),
    .key_id      (key_id),
    .key_wdata   (key_wdata),
    .cmd_start   (cmd_start),
    .cmd_mode    (cmd_mode),
    .busy        (busy),
    .cmd_done    (cmd_done),
    .res_rd_id   (res_rd_id),
    .res_rd_data (res_rd_data),
    .verify_ok   (verify_ok),
    .pm_start    (pm_start),
    .pm_op       (pm_op),
    .pm_id       (pm_id),
    .pm_done     (pm_done),
    .core_addr   (core_addr),
    .core_we     (core_we),
    .core_wdata  (core_wdata),
    .core_rdata  (core_rdata)
  );

  always #(CLK_NS / 2) clka = ~clka;

  // All driving and sampling happens 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge clka);
    #1;
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic write_key(input logic [5:0] id, input logic [31:0] data);
    next_cycle();
    key_we    = 1'b1;
    key_id    = id;
    key_wdata = data;
    next_cycle();
    key_we    = 1'b0;
  endtask

  task automatic read_slot(input logic [5:0] addr, output logic [31:0] data);
    core_addr = addr;
    #1;
    data = core_rdata;
  endtask

  task automatic read_result(input logic [5:0] id, output logic [31:0] data);
    res_rd_id = id;
    #1;
    data = res_rd_data;
  endtask

  task automatic write_slot(input logic [5:0] addr, input logic [31:0] data);
    core_addr  = addr;
    core_wdata = data;
    core_we    = 1'b1;
    next_cycle();
    core_we    = 1'b0;
  endtask

  // --------------------
  // Core model
  // --------------------
  task automatic serve_core();
    logic [3:0]  op;
    logic [31:0] word;
    int          delay;
    op    = pm_op;
    delay = 2 + int'($unsigned($random(seed)) % 8);
    op_log.push_back(op);
    id_log.push_back(pm_id);
    // Operands must already sit in their slots when the first SIGN arrives
    if (op == DSA_UOP_SIGN && !sign_seen) begin
      sign_seen = 1'b1;
      read_slot(UOP_OPR_HASH_MSG, word);
      compare_word("sign msg slot", pat[1], word);
      read_slot(UOP_OPR_PRIVKEY, word);
      compare_word("sign privkey slot", pat[0], word);
    end
    repeat (delay) next_cycle();
    case (op)
      DSA_UOP_KEYGEN: begin
        write_slot(UOP_OPR_QX_AFFN, pat[8]);
        write_slot(UOP_OPR_QY_AFFN, pat[9]);
      end
      DSA_UOP_SIGN: begin
        write_slot(UOP_OPR_SIGN_R, pat[10]);
        write_slot(UOP_OPR_SIGN_S, pat[11]);
      end
      DSA_UOP_VERIFY2: write_slot(UOP_OPR_QX_AFFN, verify_qx);
      default: ;
    endcase
    pm_done = 1'b1;
    next_cycle();
    pm_done = 1'b0;
  endtask

  // Start one program, serve the core, then watch for stray cmd_done pulses
  task automatic run_cmd(input logic [1:0] mode, input string name, input bit poke_busy);
    int cyc;
    int tail;
    cyc        = 0;
    done_count = 0;
    tail       = poke_busy ? 90 : 4;
    op_log.delete();
    id_log.delete();
    next_cycle();
    cmd_mode  = mode;
    cmd_start = 1'b1;
    next_cycle();
    cmd_start = 1'b0;
    while (done_count == 0) begin
      next_cycle();
      cyc++;
      cmd_start = 1'b0;
      if (poke_busy && cyc == 4) begin
        if (!busy) begin
          err_count++;
          $display("%s: busy is low while the program should be running", name);
        end
        // A second start while busy, which must be dropped
        cmd_mode  = DSA_MODE_INIT;
        cmd_start = 1'b1;
      end
      if (pm_start) begin
        serve_core();
      end
      if (cmd_done) begin
        done_count++;
      end
    end
    repeat (tail) begin
      next_cycle();
      if (cmd_done) begin
        done_count++;
      end
    end
    compare_word({name, " cmd_done count"}, 32'd1, 32'(done_count));
    if (busy) begin
      err_count++;
      $display("%s: busy still high after the program finished", name);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] word;
    logic [31:0] const_exp [9];
    logic [3:0]  kg_ops [4];
    logic [5:0]  kg_ids [4];
    reset_n    = 1'b0;
    key_we     = 1'b0;
    key_id     = '0;
    key_wdata  = '0;
    cmd_start  = 1'b0;
    cmd_mode   = '0;
    res_rd_id  = '0;
    pm_done    = 1'b0;
    core_addr  = '0;
    core_we    = 1'b0;
    core_wdata = '0;
    sign_seen  = 1'b0;
    verify_qx  = '0;
    seed       = 32'h9124;
    $readmemh("ecc_dsa_patterns.mem", pat);
    repeat (3) @(posedge clka);
    #1;
    reset_n = 1'b1;
    if (busy || pm_start || cmd_done || verify_ok) begin
      err_count++;
      $display("Control outputs are not idle after reset");
    end

    // Constant slots start out holding an address-tagged filler
    for (int i = 0; i < 9; i++) begin
      write_slot(UOP_OPR_CONST_ZERO + 6'(i), {26'h155_AA55, UOP_OPR_CONST_ZERO + 6'(i)});
    end

    // Init loads every constant slot
    run_cmd(DSA_MODE_INIT, "init", 1'b0);
    const_exp = '{`ECC_CONST_ZERO, `ECC_CONST_ONE, `ECC_CONST_A, `ECC_CONST_3B,
                  `ECC_CONST_R2P, `ECC_CONST_GX, `ECC_CONST_GY, `ECC_CONST_R2Q,
                  `ECC_CONST_ONEQ};
    for (int i = 0; i < 9; i++) begin
      read_slot(UOP_OPR_CONST_ZERO + 6'(i), word);
      compare_word($sformatf("init const slot %0d", i), const_exp[i], word);
    end

    write_key(PRIVKEY_ID, pat[0]);
    write_key(MSG_ID, pat[1]);
    write_key(LAMBDA_ID, pat[2]);
    write_key(MASKING_ID, pat[3]);
    write_key(R_ID, pat[4]);
    write_key(S_ID, pat[5]);
    write_key(PUBKEYX_ID, pat[6]);
    write_key(PUBKEYY_ID, pat[7]);

    // Keygen, with a start pulse while busy
    run_cmd(DSA_MODE_KEYGEN, "keygen", 1'b1);
    kg_ops = '{DSA_UOP_HMAC_DRBG, DSA_UOP_SCALAR_SCA, DSA_UOP_WR_SCALAR, DSA_UOP_KEYGEN};
    kg_ids = '{NOP_ID, SCALAR_G_ID, SCALAR_ID, NOP_ID};
    compare_word("keygen core op count", 32'd4, 32'(op_log.size()));
    for (int i = 0; i < 4 && i < op_log.size(); i++) begin
      compare_word($sformatf("keygen core op %0d", i), 32'(kg_ops[i]), 32'(op_log[i]));
    end
    for (int i = 0; i < 4 && i < id_log.size(); i++) begin
      compare_word($sformatf("keygen core id %0d", i), 32'(kg_ids[i]), 32'(id_log[i]));
    end
    read_result(PUBKEYX_ID, word);
    compare_word("keygen pubkey x", pat[14], word);
    read_result(PUBKEYY_ID, word);
    compare_word("keygen pubkey y", pat[15], word);

    run_cmd(DSA_MODE_SIGN, "sign", 1'b0);
    if (!sign_seen) begin
      err_count++;
      $display("Sign program never sent a SIGN command to the core");
    end
    read_result(R_ID, word);
    compare_word("sign r", pat[16], word);
    read_result(S_ID, word);
    compare_word("sign s", pat[17], word);

    // Verify once with the matching x, once with a wrong one
    verify_qx = pat[12];
    run_cmd(DSA_MODE_VERIFY, "verify match", 1'b0);
    compare_word("verify match flag", pat[18], {31'b0, verify_ok});
    verify_qx = pat[13];
    run_cmd(DSA_MODE_VERIFY, "verify mismatch", 1'b0);
    compare_word("verify mismatch flag", pat[19], {31'b0, verify_ok});

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the DUT stopped making progress before the tests finished");
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: ecc_dsa_patterns.mem
// One 32-bit hex word per line. Words 0-7 host inputs (privkey, msg, lambda, masking, r, s, Qx, Qy),
// 8-13 core results (keygen Qx Qy, sign r s, verify Qx match and mismatch), 14-19 expected outputs
1A2B3C4D
C0FFEE11
13579BDF
2468ACE0
A5A51234
5A5A4321
7E570001
7E570002
7E570001
7E570002
A5A51234
5A5A4321
A5A51234
A5A51235
7E570001
7E570002
A5A51234
5A5A4321
00000001
00000000

// File: ecc_dsa_top.f
+incdir+.
ecc_dsa_pkg.sv
ecc_dsa_uop_if.sv
ecc_dsa_sequencer.sv
ecc_dsa_ctrl.sv
ecc_dsa_uop_exec.sv
ecc_dsa_key_bank.sv
ecc_dsa_result_bank.sv
ecc_dsa_top.sv
tb_ecc_dsa_top.sv

// File: Makefile
# Verilator build and run of the ECDSA control engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_ecc_dsa_top -f ecc_dsa_top.f

# Pass only when the testbench prints its pass message
run: compile
	./obj_dir/Vtb_ecc_dsa_top | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
